//--- src/cluster_pkg.sv
/*
 * Cluster egress shared definitions
 * Widths, FIFO depth, outstanding limit, vector types and arbiter states
 */

`default_nettype none

package cluster_pkg;

  // --------------------------------------------------
  // Request and ID widths
  // --------------------------------------------------
  localparam int NUM_PORTS  = 2;
  localparam int ADDR_W     = 32;
  localparam int CORE_ID_W  = 2;
  localparam int PORT_IDX_W = 1;
  // Port index sits above the core ID
  localparam int SOC_ID_W   = PORT_IDX_W + CORE_ID_W;

  // --------------------------------------------------
  // CDC FIFO and flow control
  // --------------------------------------------------
  localparam int LOG_DEPTH       = 2;
  localparam int PTR_W           = LOG_DEPTH + 1;
  localparam int ENTRY_W         = SOC_ID_W + ADDR_W;
  localparam int MAX_OUTSTANDING = 3;
  localparam int CNT_W           = 2;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [CORE_ID_W-1:0]  core_id_t;
  typedef logic [SOC_ID_W-1:0]   soc_id_t;
  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [PTR_W-1:0]      gray_ptr_t;
  // Entry layout, widened ID in the upper bits
  typedef logic [ENTRY_W-1:0]    entry_t;

  typedef enum logic {
    ARB_IDLE,
    ARB_HOLD
  } arb_state_e;

endpackage

`default_nettype wire

//--- src/egress_arbiter.sv
/*
 * Egress arbiter
 * Round-robin grant over the requester ports, held under back-pressure,
 * with the port index prepended to the core ID
 */

`default_nettype none

module egress_arbiter import cluster_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic     [NUM_PORTS-1:0]       req_valid_i,
  output logic     [NUM_PORTS-1:0]       req_ready_o,
  input  core_id_t [NUM_PORTS-1:0]       req_id_i,
  input  addr_t    [NUM_PORTS-1:0]       req_addr_i,
  input  logic     [NUM_PORTS-1:0]       port_block_i,
  output logic                           push_valid_o,
  input  logic                           push_ready_i,
  output entry_t                         push_entry_o,
  output logic     [NUM_PORTS-1:0]       issue_fire_o
);

  arb_state_e state_q;
  port_idx_t  grant_q;
  port_idx_t  last_q;
  port_idx_t  pick;
  port_idx_t  grant;
  logic       found;
  logic       fire;

  // Search starts at the port after the last one served
  always_comb begin
    int idx;
    pick  = last_q;
    found = 1'b0;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      idx = (int'(last_q) + k) % NUM_PORTS;
      if (!found && req_valid_i[idx] && !port_block_i[idx]) begin
        pick  = port_idx_t'(idx);
        found = 1'b1;
      end
    end
  end

  assign grant        = (state_q == ARB_HOLD) ? grant_q : pick;
  assign push_valid_o = (state_q == ARB_HOLD) || found;
  assign fire         = push_valid_o && push_ready_i;
  assign push_entry_o = {grant, req_id_i[grant], req_addr_i[grant]};

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      req_ready_o[i]  = push_valid_o && push_ready_i && !port_block_i[i]
                        && (grant == port_idx_t'(i));
      issue_fire_o[i] = fire && (grant == port_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ARB_IDLE;
      grant_q <= '0;
      last_q  <= '0;
    end else begin
      if (fire) begin
        last_q <= grant;
      end
      case (state_q)
        ARB_IDLE: begin
          if (push_valid_o && !push_ready_i) begin
            state_q <= ARB_HOLD;
            grant_q <= grant;
          end
        end
        ARB_HOLD: begin
          if (push_ready_i) state_q <= ARB_IDLE;
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // Stalled request stays presented and unchanged
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_valid_o && !push_ready_i |=> push_valid_o && $stable(push_entry_o))
    else $error("arbiter dropped or changed a stalled request");

endmodule

`default_nettype wire

//--- src/outstanding_counter.sv
/*
 * Outstanding transaction counter
 * One saturating count per port, blocks the port at the limit
 */

`default_nettype none

module outstanding_counter import cluster_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [NUM_PORTS-1:0] issue_fire_i,
  input  logic [NUM_PORTS-1:0] done_fire_i,
  output logic [NUM_PORTS-1:0] port_block_o
);

  logic [NUM_PORTS-1:0][CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        // Issue and done together leave the count as is
        case ({issue_fire_i[i], done_fire_i[i]})
          2'b10: if (cnt_q[i] != CNT_W'(MAX_OUTSTANDING)) cnt_q[i] <= cnt_q[i] + 1'b1;
          2'b01: if (cnt_q[i] != '0) cnt_q[i] <= cnt_q[i] - 1'b1;
          default: ;
        endcase
      end
    end
  end

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
    assign port_block_o[i] = (cnt_q[i] == CNT_W'(MAX_OUTSTANDING));

    // Completion without a matching request
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      done_fire_i[i] |-> cnt_q[i] != '0)
      else $error("completion on port %0d with nothing open", i);

    a_no_issue_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      issue_fire_i[i] |-> !port_block_o[i])
      else $error("request issued on blocked port %0d", i);
  end

endmodule

`default_nettype wire

//--- src/async_req_src.sv
/*
 * Async request FIFO, source half
 * Entry array and gray write pointer go out, gray read pointer comes back
 */

`default_nettype none

module async_req_src import cluster_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         push_valid_i,
  output logic                         push_ready_o,
  input  entry_t                       push_entry_i,
  output gray_ptr_t                    wptr_o,
  output entry_t [2**LOG_DEPTH-1:0]    data_o,
  input  gray_ptr_t                    rptr_i
);

  entry_t [2**LOG_DEPTH-1:0] mem_q;
  logic      [PTR_W-1:0]     wptr_bin_q;
  logic      [PTR_W-1:0]     wptr_bin_d;
  gray_ptr_t                 wptr_gray_q;
  gray_ptr_t                 rptr_sync1_q;
  gray_ptr_t                 rptr_sync2_q;
  logic                      full;
  logic                      write;
  logic      [PTR_W-1:0]     fill_cnt;

  function automatic logic [PTR_W-1:0] gray2bin(input gray_ptr_t g);
    logic [PTR_W-1:0] b;
    b[PTR_W-1] = g[PTR_W-1];
    for (int i = PTR_W - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // --------------------------------------------------
  // Read pointer synchronizer
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rptr_sync1_q <= '0;
      rptr_sync2_q <= '0;
    end else begin
      rptr_sync1_q <= rptr_i;
      rptr_sync2_q <= rptr_sync1_q;
    end
  end

  // Full when a whole lap ahead: top two gray bits flipped
  assign full = (wptr_gray_q == {~rptr_sync2_q[PTR_W-1:PTR_W-2], rptr_sync2_q[PTR_W-3:0]});
  assign push_ready_o = !full;
  assign write        = push_valid_i && push_ready_o;
  assign wptr_bin_d   = wptr_bin_q + 1'b1;

  // --------------------------------------------------
  // Write side
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else if (write) begin
      wptr_bin_q  <= wptr_bin_d;
      wptr_gray_q <= wptr_bin_d ^ (wptr_bin_d >> 1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (write) mem_q[wptr_bin_q[LOG_DEPTH-1:0]] <= push_entry_i;
  end

  assign wptr_o = wptr_gray_q;
  assign data_o = mem_q;

  // Binary cross-check of the gray full logic against the remote pointer
  assign fill_cnt = wptr_bin_q - gray2bin(rptr_sync2_q);

  a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    write |-> fill_cnt < PTR_W'(2**LOG_DEPTH))
    else $error("write into a FIFO slot not yet read");

endmodule

`default_nettype wire

//--- src/resp_router.sv
/*
 * Response router
 * Splits the widened ID and steers each response to its issuing port
 */

`default_nettype none

module resp_router import cluster_pkg::*; (
  input  logic                 resp_valid_i,
  output logic                 resp_ready_o,
  input  soc_id_t              resp_id_i,
  input  logic                 resp_err_i,
  output logic [NUM_PORTS-1:0] port_resp_valid_o,
  input  logic [NUM_PORTS-1:0] port_resp_ready_i,
  output core_id_t             port_resp_id_o,
  output logic                 port_resp_err_o,
  output logic [NUM_PORTS-1:0] done_fire_o
);

  port_idx_t port_sel;
  logic      resp_fire;

  // Upper ID bits name the port
  assign port_sel  = resp_id_i[SOC_ID_W-1 -: PORT_IDX_W];

  // A stalled port holds the shared channel
  assign resp_ready_o = port_resp_ready_i[port_sel];
  assign resp_fire    = resp_valid_i && resp_ready_o;

  assign port_resp_id_o  = resp_id_i[CORE_ID_W-1:0];
  assign port_resp_err_o = resp_err_i;

  // --------------------------------------------------
  // Per-port valid and completion
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      port_resp_valid_o[i] = resp_valid_i && (port_sel == port_idx_t'(i));
      done_fire_o[i]       = resp_fire && (port_sel == port_idx_t'(i));
    end
  end

endmodule

`default_nettype wire

//--- src/cluster_egress_top.sv
/*
 * Cluster egress top
 * Arbiter, outstanding limit, async request FIFO and response router
 */

`default_nettype none

module cluster_egress_top import cluster_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Requester ports
  input  logic     [NUM_PORTS-1:0]    req_valid_i,
  output logic     [NUM_PORTS-1:0]    req_ready_o,
  input  core_id_t [NUM_PORTS-1:0]    req_id_i,
  input  addr_t    [NUM_PORTS-1:0]    req_addr_i,
  // CDC toward the system domain
  output gray_ptr_t                   wptr_o,
  output entry_t [2**LOG_DEPTH-1:0]   data_o,
  input  gray_ptr_t                   rptr_i,
  // Response channel
  input  logic                        resp_valid_i,
  output logic                        resp_ready_o,
  input  soc_id_t                     resp_id_i,
  input  logic                        resp_err_i,
  output logic     [NUM_PORTS-1:0]    port_resp_valid_o,
  input  logic     [NUM_PORTS-1:0]    port_resp_ready_i,
  output core_id_t                    port_resp_id_o,
  output logic                        port_resp_err_o
);

  logic                 push_valid;
  logic                 push_ready;
  entry_t               push_entry;
  logic [NUM_PORTS-1:0] port_block;
  logic [NUM_PORTS-1:0] issue_fire;
  logic [NUM_PORTS-1:0] done_fire;

  egress_arbiter u_arbiter (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .req_valid_i  ( req_valid_i ),
    .req_ready_o  ( req_ready_o ),
    .req_id_i     ( req_id_i    ),
    .req_addr_i   ( req_addr_i  ),
    .port_block_i ( port_block  ),
    .push_valid_o ( push_valid  ),
    .push_ready_i ( push_ready  ),
    .push_entry_o ( push_entry  ),
    .issue_fire_o ( issue_fire  )
  );

  outstanding_counter u_counter (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .issue_fire_i ( issue_fire ),
    .done_fire_i  ( done_fire  ),
    .port_block_o ( port_block )
  );

  async_req_src u_req_fifo (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .push_valid_i ( push_valid ),
    .push_ready_o ( push_ready ),
    .push_entry_i ( push_entry ),
    .wptr_o       ( wptr_o     ),
    .data_o       ( data_o     ),
    .rptr_i       ( rptr_i     )
  );

  resp_router u_router (
    .resp_valid_i      ( resp_valid_i      ),
    .resp_ready_o      ( resp_ready_o      ),
    .resp_id_i         ( resp_id_i         ),
    .resp_err_i        ( resp_err_i        ),
    .port_resp_valid_o ( port_resp_valid_o ),
    .port_resp_ready_i ( port_resp_ready_i ),
    .port_resp_id_o    ( port_resp_id_o    ),
    .port_resp_err_o   ( port_resp_err_o   ),
    .done_fire_o       ( done_fire         )
  );

endmodule

`default_nettype wire

//--- verif/tb_soc_sink.sv
/*
 * System-domain CDC sink model
 * Syncs the gray write pointer, drains entries with random stalls
 */

`default_nettype none

module tb_soc_sink import cluster_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  gray_ptr_t                 wptr_i,
  input  entry_t [2**LOG_DEPTH-1:0] data_i,
  output gray_ptr_t                 rptr_o
);

  logic [PTR_W-1:0] rbin_q;
  logic [PTR_W-1:0] rbin_nxt;
  gray_ptr_t        wsync1_q;
  gray_ptr_t        wsync2_q;
  // Entries in read order, drained by the testbench top
  entry_t           rd_q[$];
  int               reads = 0;

  assign rbin_nxt = rbin_q + 1'b1;

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wsync1_q <= '0;
      wsync2_q <= '0;
      rbin_q   <= '0;
      rptr_o   <= '0;
    end else begin
      wsync1_q <= wptr_i;
      wsync2_q <= wsync1_q;
      // Not empty once the synced write pointer moved past us
      if (rptr_o != wsync2_q && $urandom_range(0, 2) != 0) begin
        rd_q.push_back(data_i[rbin_q[LOG_DEPTH-1:0]]);
        reads  <= reads + 1;
        rbin_q <= rbin_nxt;
        rptr_o <= rbin_nxt ^ (rbin_nxt >> 1);
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_cluster_egress.sv
/*
 * Cluster egress testbench
 * Random requesters and responses checked against a reference model
 */

`default_nettype none

module tb_cluster_egress import cluster_pkg::*;;

  localparam int SEED          = 22;
  localparam int REQS_PER_TEST = 200;
  localparam int NUM_TRAFFIC   = 2;
  localparam int TIMEOUT_CYC   = 40 * REQS_PER_TEST * NUM_TRAFFIC + 100;

  logic                      clk_i;
  logic                      sink_clk;
  logic                      rst_n_i;
  logic [NUM_PORTS-1:0]      req_valid_i;
  logic [NUM_PORTS-1:0]      req_ready_o;
  core_id_t [NUM_PORTS-1:0]  req_id_i;
  addr_t [NUM_PORTS-1:0]     req_addr_i;
  gray_ptr_t                 wptr_o;
  gray_ptr_t                 rptr_i;
  entry_t [2**LOG_DEPTH-1:0] data_o;
  logic                      resp_valid_i;
  logic                      resp_ready_o;
  soc_id_t                   resp_id_i;
  logic                      resp_err_i;
  logic [NUM_PORTS-1:0]      port_resp_valid_o;
  logic [NUM_PORTS-1:0]      port_resp_ready_i;
  core_id_t                  port_resp_id_o;
  logic                      port_resp_err_o;

  // Reference model state
  entry_t               exp_q[NUM_PORTS][$];
  int                   out_cnt[NUM_PORTS];
  port_idx_t            pend_port[$];
  core_id_t             pend_core[$];
  int                   pend_due[$];
  port_idx_t            resp_port;
  core_id_t             resp_core;
  logic                 resp_err_exp;
  int                   accepted;
  int                   issued;
  int                   cyc;
  logic [NUM_PORTS-1:0] hs;
  logic                 resp_fire;
  logic                 have_last;
  port_idx_t            last_port;
  logic                 both_run;
  int                   alt_checks;
  int                   blocked_seen;
  int                   errors;
  int                   tests_run;
  int                   tests_failed;
  int                   wd_cycles;
  int unsigned          seed_val;

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    sink_clk = 1'b0;
    forever #35 sink_clk = ~sink_clk;
  end

  cluster_egress_top dut_i (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .req_valid_i       ( req_valid_i       ),
    .req_ready_o       ( req_ready_o       ),
    .req_id_i          ( req_id_i          ),
    .req_addr_i        ( req_addr_i        ),
    .wptr_o            ( wptr_o            ),
    .data_o            ( data_o            ),
    .rptr_i            ( rptr_i            ),
    .resp_valid_i      ( resp_valid_i      ),
    .resp_ready_o      ( resp_ready_o      ),
    .resp_id_i         ( resp_id_i         ),
    .resp_err_i        ( resp_err_i        ),
    .port_resp_valid_o ( port_resp_valid_o ),
    .port_resp_ready_i ( port_resp_ready_i ),
    .port_resp_id_o    ( port_resp_id_o    ),
    .port_resp_err_o   ( port_resp_err_o   )
  );

  tb_soc_sink u_sink (
    .clk_i   ( sink_clk ),
    .rst_n_i ( rst_n_i  ),
    .wptr_i  ( wptr_o   ),
    .data_i  ( data_o   ),
    .rptr_o  ( rptr_i   )
  );

  initial begin
    wd_cycles = 0;
    while (wd_cycles < TIMEOUT_CYC) begin
      @(posedge clk_i);
      wd_cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", wd_cycles);
    $display("sim failed");
    $finish;
  end

  // --------------------------------------------------
  // Reporting
  // --------------------------------------------------
  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  task automatic finish_test(input string name, input int err_start, input string note);
    tests_run++;
    if (errors == err_start) begin
      $display("Test %s: PASS %s", name, note);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL with %0d errors %s", name, errors - err_start, note);
    end
  endtask

  // --------------------------------------------------
  // Sampling of pre-edge values at the clock edge
  // --------------------------------------------------
  task automatic observe_requests();
    logic   both;
    entry_t e;
    both = 1'b1;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (!req_valid_i[i] || out_cnt[i] >= MAX_OUTSTANDING) both = 1'b0;
    end
    both_run = both_run && both;
    for (int i = 0; i < NUM_PORTS; i++) begin
      hs[i] = req_valid_i[i] && req_ready_o[i];
      if (req_valid_i[i] && out_cnt[i] >= MAX_OUTSTANDING) blocked_seen++;
      if (hs[i]) begin
        if (out_cnt[i] >= MAX_OUTSTANDING) begin
          report_failure($sformatf("port %0d accepted with %0d open", i, out_cnt[i]));
        end
        // Priority moves on when both contended since the last grant
        if (have_last && both_run) begin
          alt_checks++;
          if (last_port == port_idx_t'(i)) begin
            report_failure($sformatf("port %0d served twice in a row", i));
          end
        end
        e = {port_idx_t'(i), req_id_i[i], req_addr_i[i]};
        exp_q[i].push_back(e);
        out_cnt[i]++;
        accepted++;
        have_last = 1'b1;
        last_port = port_idx_t'(i);
        both_run  = 1'b1;
      end
    end
    if (hs == '1) report_failure("both ports accepted in one cycle");
  endtask

  task automatic observe_responses();
    resp_fire = 1'b0;
    if (resp_valid_i) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (port_resp_valid_o[i] !== (resp_port == port_idx_t'(i))) begin
          report_mismatch($sformatf("port_resp_valid_o[%0d]", i),
                          64'(port_resp_valid_o[i]), 64'(resp_port == port_idx_t'(i)));
        end
      end
      if (port_resp_id_o !== resp_core) begin
        report_mismatch("port_resp_id_o", 64'(port_resp_id_o), 64'(resp_core));
      end
      if (port_resp_err_o !== resp_err_exp) begin
        report_mismatch("port_resp_err_o", 64'(port_resp_err_o), 64'(resp_err_exp));
      end
      if (resp_ready_o !== port_resp_ready_i[resp_port]) begin
        report_mismatch("resp_ready_o", 64'(resp_ready_o), 64'(port_resp_ready_i[resp_port]));
      end
      // Completion only when the named port takes it
      if (port_resp_ready_i[resp_port]) begin
        resp_fire = 1'b1;
        out_cnt[resp_port]--;
      end
    end else if (port_resp_valid_o !== '0) begin
      report_mismatch("port_resp_valid_o", 64'(port_resp_valid_o), 64'(0));
    end
  endtask

  task automatic collect_sink();
    entry_t    got;
    entry_t    exp;
    port_idx_t p;
    while (u_sink.rd_q.size() > 0) begin
      got = u_sink.rd_q.pop_front();
      p   = got[ENTRY_W-1 -: PORT_IDX_W];
      if (exp_q[p].size() == 0) begin
        report_failure($sformatf("sink read 0x%0h with nothing open on port %0d", got, p));
      end else begin
        exp = exp_q[p].pop_front();
        if (got[ENTRY_W-1:ADDR_W] !== exp[ENTRY_W-1:ADDR_W]) begin
          report_mismatch("data_o id", 64'(got[ENTRY_W-1:ADDR_W]), 64'(exp[ENTRY_W-1:ADDR_W]));
        end
        if (got[ADDR_W-1:0] !== exp[ADDR_W-1:0]) begin
          report_mismatch("data_o addr", 64'(got[ADDR_W-1:0]), 64'(exp[ADDR_W-1:0]));
        end
        pend_port.push_back(exp[ENTRY_W-1 -: PORT_IDX_W]);
        pend_core.push_back(exp[ADDR_W +: CORE_ID_W]);
        pend_due.push_back(cyc + int'($urandom_range(0, 12)));
      end
    end
  endtask

  // --------------------------------------------------
  // Driving after the edge
  // --------------------------------------------------
  task automatic drive_requests();
    for (int i = 0; i < NUM_PORTS; i++) begin
      // Valid and payload hold until the handshake
      if (!req_valid_i[i] || hs[i]) begin
        if (issued < REQS_PER_TEST && $urandom_range(0, 3) != 0) begin
          req_valid_i[i] <= 1'b1;
          req_id_i[i]    <= core_id_t'($urandom);
          req_addr_i[i]  <= addr_t'($urandom);
          issued++;
        end else begin
          req_valid_i[i] <= 1'b0;
        end
      end
    end
  endtask

  task automatic drive_responses(input logic hold);
    if (!resp_valid_i || resp_fire) begin
      if (!hold && pend_port.size() > 0 && pend_due[0] <= cyc) begin
        resp_port    = pend_port.pop_front();
        resp_core    = pend_core.pop_front();
        resp_err_exp = 1'($urandom_range(0, 1));
        resp_valid_i <= 1'b1;
        resp_id_i    <= {resp_port, resp_core};
        resp_err_i   <= resp_err_exp;
        pend_due.delete(0);
      end else begin
        resp_valid_i <= 1'b0;
      end
    end
    for (int i = 0; i < NUM_PORTS; i++) begin
      port_resp_ready_i[i] <= ($urandom_range(0, 3) != 0);
    end
  endtask

  task automatic run_traffic(input string name, input logic use_hold);
    int   err_start;
    int   start_cyc;
    int   acc_start;
    logic done;
    logic hold;
    err_start    = errors;
    start_cyc    = cyc;
    acc_start    = accepted;
    issued       = 0;
    alt_checks   = 0;
    blocked_seen = 0;
    done         = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      cyc++;
      // Responses withheld in alternating 40-cycle windows
      hold = use_hold && (((cyc - start_cyc) / 40) % 2 == 0);
      observe_requests();
      observe_responses();
      collect_sink();
      if (accepted - u_sink.reads > 2**LOG_DEPTH) begin
        report_failure($sformatf("FIFO holds %0d entries", accepted - u_sink.reads));
      end
      done = (issued == REQS_PER_TEST) && (accepted - acc_start == REQS_PER_TEST)
             && (pend_port.size() == 0) && !(resp_valid_i && !resp_fire);
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (out_cnt[i] != 0) done = 1'b0;
      end
      if (!done) begin
        drive_requests();
        drive_responses(hold);
      end
    end
    resp_valid_i <= 1'b0;
    req_valid_i  <= '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (exp_q[i].size() != 0) report_failure("accepted requests never reached the sink");
    end
    if (use_hold && blocked_seen == 0) report_failure("no port ever reached its limit");
    if (!use_hold && alt_checks == 0) report_failure("no contended grant was seen");
    finish_test(name, err_start,
                $sformatf("(%0d alternations, %0d blocked cycles)", alt_checks, blocked_seen));
  endtask

  task automatic check_reset_state();
    int err_start;
    err_start = errors;
    @(negedge clk_i);
    if (req_ready_o !== '0) report_mismatch("req_ready_o", 64'(req_ready_o), 64'(0));
    if (port_resp_valid_o !== '0) begin
      report_mismatch("port_resp_valid_o", 64'(port_resp_valid_o), 64'(0));
    end
    if (resp_ready_o !== 1'b0) report_mismatch("resp_ready_o", 64'(resp_ready_o), 64'(0));
    if (wptr_o !== '0) report_mismatch("wptr_o", 64'(wptr_o), 64'(0));
    finish_test("reset_state", err_start, "");
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    seed_val          = $urandom(SEED);
    rst_n_i           <= 1'b0;
    req_valid_i       <= '0;
    req_id_i          <= '0;
    req_addr_i        <= '0;
    resp_valid_i      <= 1'b0;
    resp_id_i         <= '0;
    resp_err_i        <= 1'b0;
    port_resp_ready_i <= '0;
    errors            = 0;
    tests_run         = 0;
    tests_failed      = 0;
    accepted          = 0;
    cyc               = 0;
    have_last         = 1'b0;
    last_port         = '0;
    both_run          = 1'b1;
    hs                = '0;
    resp_fire         = 1'b0;
    resp_port         = '0;
    resp_core         = '0;
    resp_err_exp      = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      out_cnt[i] = 0;
    end
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    check_reset_state();
    run_traffic("random_traffic", 1'b0);
    run_traffic("resp_backpressure", 1'b1);
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
src/cluster_pkg.sv
src/egress_arbiter.sv
src/outstanding_counter.sv
src/async_req_src.sv
src/resp_router.sv
src/cluster_egress_top.sv
verif/tb_soc_sink.sv
verif/tb_cluster_egress.sv

//--- Makefile
# Verilator build and run for the cluster egress testbench

VERILATOR ?= verilator
TOP       ?= tb_cluster_egress
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Result: FAIL"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Result: FAIL, no result line in $(LOG)"; exit 1; \
	else \
	  echo "Result: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
